/* rtl/cart_cfg.svh */
// Download widths, cheat index, header offsets and APB register map macros
`ifndef CART_CFG_SVH
`define CART_CFG_SVH

// ======================================================================
// Download stream
// ======================================================================
`define CART_ADDR_W       25
`define CART_DATA_W       16
// Index of a cheat code download, everything else is a cartridge
`define CART_CODE_INDEX   8'hff

// Copier header in front of the image
`define CART_COPIER_OFS   25'h0000200
// Byte address of the size field, RAM size sits 2 bytes higher
`define CART_LOROM_INFO   25'h0007fd6
`define CART_HIROM_INFO   25'h000ffd6
`define CART_EXHIROM_INFO 25'h040ffd6

// ======================================================================
// APB register map
// ======================================================================
`define CART_REG_CTRL     8'h00
`define CART_REG_INFO     8'h04
`define CART_REG_ROM_MASK 8'h08
`define CART_REG_RAM_MASK 8'h0c
`define CART_REG_CHEATS   8'h10
`endif

/* rtl/cart_pkg.sv */
// Shared types of the cartridge loader: download word, settings, results and APB bus
`include "cart_cfg.svh"
`default_nettype none

package cart_pkg;

	// One word of the download stream after classification
	typedef struct packed {
		logic                    is_code;
		logic [`CART_ADDR_W-1:0] addr;
		logic [`CART_DATA_W-1:0] data;
	} dl_word_t;

	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} header_mode_e;

	typedef enum logic [1:0] {
		REG_AUTO = 2'd0,
		REG_NTSC = 2'd1,
		REG_PAL  = 2'd2
	} region_mode_e;

	// User settings from the CTRL register
	typedef struct packed {
		header_mode_e header_mode;
		region_mode_e region_mode;
		logic         cheat_en;
	} cart_ctrl_t;

	// Parse results
	typedef struct packed {
		logic [7:0]  rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
		logic        pal;
	} rom_info_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

endpackage

`default_nettype wire

/* rtl/dl_classify.sv */
// Download input stage: registers the word stream, tags code words, detects download start
`include "cart_cfg.svh"
`default_nettype none

module dl_classify
	import cart_pkg::*;
(
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire                    dl_active,
	input  wire [7:0]              dl_index,
	input  wire                    dl_wr,
	input  wire [`CART_ADDR_W-1:0] dl_addr,
	input  wire [`CART_DATA_W-1:0] dl_data,
	output dl_word_t               dl_word,
	output logic                   dl_valid,
	output logic                   dl_busy,
	output logic                   dl_start
);

	logic is_code;

	assign is_code = (dl_index == `CART_CODE_INDEX);

	// Word payload, held between writes
	always_ff @(posedge clk_sys) begin
		if (dl_wr) begin
			dl_word.is_code <= is_code;
			dl_word.addr    <= dl_addr;
			dl_word.data    <= dl_data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_valid <= 1'b0;
			dl_busy  <= 1'b0;
			dl_start <= 1'b0;
		end else begin
			dl_valid <= dl_wr & dl_active;
			dl_busy  <= dl_active;
			// Rising edge of a cartridge download
			dl_start <= dl_active & ~dl_busy & ~is_code;
		end
	end

endmodule

`default_nettype wire

/* rtl/cart_header_parser.sv */
// Cartridge header parser: ROM type, ROM and RAM sizes, address masks and video region
`include "cart_cfg.svh"
`default_nettype none

module cart_header_parser
	import cart_pkg::*;
(
	input  wire               clk_sys,
	input  wire               reset,
	input  wire dl_word_t     dl_word,
	input  wire               dl_valid,
	input  wire               dl_busy,
	input  wire               dl_start,
	input  wire header_mode_e header_mode,
	input  wire region_mode_e region_mode,
	output rom_info_t         rom_info
);

	logic [3:0]              rom_size;
	logic [3:0]              ram_size;
	logic                    size_valid;
	logic [7:0]              rom_type;
	logic                    hdr_region;
	logic                    pal;
	logic                    forced;
	logic [`CART_ADDR_W-1:0] info_base;
	logic                    cart_wr;

	assign cart_wr = dl_valid & ~dl_word.is_code;

	// Size field location of the forced mapping
	always_comb begin
		forced    = 1'b1;
		info_base = `CART_LOROM_INFO;
		case (header_mode)
			HDR_LOROM:   info_base = `CART_LOROM_INFO;
			HDR_HIROM:   info_base = `CART_HIROM_INFO;
			HDR_EXHIROM: info_base = `CART_EXHIROM_INFO;
			default:     forced = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_size   <= 4'h0;
			ram_size   <= 4'h0;
			size_valid <= 1'b0;
			rom_type   <= 8'h00;
			hdr_region <= 1'b0;
		end else begin
			if (dl_start)
				hdr_region <= 1'b0;
			if (cart_wr) begin
				// First word carries the packed sizes and type
				if (dl_word.addr == '0) begin
					rom_size   <= 4'hc;
					ram_size   <= 4'h0;
					size_valid <= 1'b1;
					if (header_mode == HDR_AUTO && dl_word.data[7:0] != 8'h00)
						{ram_size, rom_size} <= dl_word.data[7:0];
					case (header_mode)
						HDR_AUTO:    rom_type <= dl_word.data[15:8];
						HDR_HIROM:   rom_type <= 8'h01;
						HDR_EXHIROM: rom_type <= 8'h02;
						default:     rom_type <= 8'h00;
					endcase
				end
				if (dl_word.addr == `CART_ADDR_W'd2)
					hdr_region <= dl_word.data[8];
				// Internal header behind the copier block
				if (forced && dl_word.addr == info_base + `CART_COPIER_OFS) begin
					rom_size   <= dl_word.data[11:8];
					size_valid <= 1'b1;
				end
				if (forced && dl_word.addr == info_base + `CART_COPIER_OFS + `CART_ADDR_W'd2)
					ram_size <= dl_word.data[3:0];
			end
		end
	end

	// Region is only allowed to move between downloads
	always_ff @(posedge clk_sys) begin
		if (reset)
			pal <= 1'b0;
		else if (!dl_busy)
			pal <= (region_mode == REG_AUTO) ? hdr_region : (region_mode == REG_PAL);
	end

	always_comb begin
		rom_info.rom_type = rom_type;
		rom_info.rom_mask = size_valid ? (24'd1024 << rom_size) - 24'd1 : 24'd0;
		rom_info.ram_mask = (ram_size != 4'h0) ? (24'd1024 << ram_size) - 24'd1 : 24'd0;
		rom_info.pal      = pal;
	end

endmodule

`default_nettype wire

/* rtl/cheat_assembler.sv */
// Cheat code assembler: collects eight download words into one 128-bit code
`default_nettype none

module cheat_assembler
	import cart_pkg::*;
(
	input  wire           clk_sys,
	input  wire           reset,
	input  wire dl_word_t dl_word,
	input  wire           dl_valid,
	input  wire           dl_start,
	output cheat_code_t   cheat_code,
	output logic          cheat_valid,
	output logic          cheat_clear
);

	logic code_wr;

	assign code_wr = dl_valid & dl_word.is_code;

	// Low half first for every field
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl_word.addr[3:0])
				4'd0:  cheat_code.flags[15:0]    <= dl_word.data;
				4'd2:  cheat_code.flags[31:16]   <= dl_word.data;
				4'd4:  cheat_code.addr[15:0]     <= dl_word.data;
				4'd6:  cheat_code.addr[31:16]    <= dl_word.data;
				4'd8:  cheat_code.compare[15:0]  <= dl_word.data;
				4'd10: cheat_code.compare[31:16] <= dl_word.data;
				4'd12: cheat_code.replace[15:0]  <= dl_word.data;
				4'd14: cheat_code.replace[31:16] <= dl_word.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			// Last word completes the code
			cheat_valid <= code_wr && (dl_word.addr[3:0] == 4'd14);
			// New code list or new cartridge drops the old codes
			cheat_clear <= dl_start | (code_wr && dl_word.addr == '0);
		end
	end

endmodule

`default_nettype wire

/* rtl/cart_apb_regs.sv */
// APB control and status registers: settings, parse results and cheat code counter
`include "cart_cfg.svh"
`default_nettype none

module cart_apb_regs
	import cart_pkg::*;
(
	input  wire            clk_sys,
	input  wire            reset,
	input  wire apb_req_t  apb_req,
	output apb_rsp_t       apb_rsp,
	input  wire rom_info_t rom_info,
	input  wire            dl_busy,
	input  wire            cheat_valid,
	input  wire            cheat_clear,
	output cart_ctrl_t     cart_ctrl
);

	logic        access;
	logic        mapped;
	logic [31:0] rdata;
	logic [31:0] cheat_cnt;

	assign access = apb_req.psel & apb_req.penable;

	// ======================================================================
	// CTRL, the only writable register
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_ctrl <= '0;
		end else if (access && apb_req.pwrite && apb_req.paddr == `CART_REG_CTRL) begin
			cart_ctrl.header_mode <= header_mode_e'(apb_req.pwdata[2:0]);
			cart_ctrl.region_mode <= region_mode_e'(apb_req.pwdata[5:4]);
			cart_ctrl.cheat_en    <= apb_req.pwdata[8];
		end
	end

	// Codes received since the last clear
	always_ff @(posedge clk_sys) begin
		if (reset || cheat_clear)
			cheat_cnt <= 32'd0;
		else if (cheat_valid)
			cheat_cnt <= cheat_cnt + 32'd1;
	end

	// Read mux
	always_comb begin
		mapped = 1'b1;
		rdata  = 32'd0;
		case (apb_req.paddr)
			`CART_REG_CTRL: rdata = {23'd0, cart_ctrl.cheat_en, 2'b00,
				cart_ctrl.region_mode, 1'b0, cart_ctrl.header_mode};
			`CART_REG_INFO:     rdata = {22'd0, dl_busy, rom_info.pal, rom_info.rom_type};
			`CART_REG_ROM_MASK: rdata = {8'd0, rom_info.rom_mask};
			`CART_REG_RAM_MASK: rdata = {8'd0, rom_info.ram_mask};
			`CART_REG_CHEATS:   rdata = cheat_cnt;
			default:            mapped = 1'b0;
		endcase
	end

	always_comb begin
		apb_rsp.prdata  = rdata;
		apb_rsp.pready  = 1'b1;
		apb_rsp.pslverr = access & (~mapped | (apb_req.pwrite & apb_req.paddr != `CART_REG_CTRL));
	end

endmodule

`default_nettype wire

/* rtl/cart_loader_top.sv */
// Cartridge loader top level: download classifier, header parser, cheat assembler, APB registers
`include "cart_cfg.svh"
`default_nettype none

module cart_loader_top
	import cart_pkg::*;
(
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire                    dl_active,
	input  wire [7:0]              dl_index,
	input  wire                    dl_wr,
	input  wire [`CART_ADDR_W-1:0] dl_addr,
	input  wire [`CART_DATA_W-1:0] dl_data,
	input  wire apb_req_t          apb_req,
	output apb_rsp_t               apb_rsp,
	output rom_info_t              rom_info,
	output cheat_code_t            cheat_code,
	output logic                   cheat_valid,
	output logic                   cheat_clear
);

	dl_word_t   dl_word;
	logic       dl_valid;
	logic       dl_busy;
	logic       dl_start;
	cart_ctrl_t cart_ctrl;
	logic       code_done;

	dl_classify u_classify (.clk_sys, .reset, .dl_active, .dl_index, .dl_wr, .dl_addr,
		.dl_data, .dl_word, .dl_valid, .dl_busy, .dl_start);

	cart_header_parser u_parser (.clk_sys, .reset, .dl_word, .dl_valid, .dl_busy,
		.dl_start, .header_mode(cart_ctrl.header_mode),
		.region_mode(cart_ctrl.region_mode), .rom_info);

	cheat_assembler u_cheats (.clk_sys, .reset, .dl_word, .dl_valid, .dl_start,
		.cheat_code, .cheat_valid(code_done), .cheat_clear);

	// Codes only reach the core with cheats enabled
	assign cheat_valid = code_done & cart_ctrl.cheat_en;

	cart_apb_regs u_regs (.clk_sys, .reset, .apb_req, .apb_rsp, .rom_info, .dl_busy,
		.cheat_valid, .cheat_clear, .cart_ctrl);

endmodule

`default_nettype wire

/* bench/cart_loader_props.sv */
// Concurrent assertions on the APB port, cheat strobes and region of the cartridge loader
`default_nettype none

module cart_loader_props
	import cart_pkg::*;
(
	input wire            clk_sys,
	input wire            reset,
	input wire apb_req_t  apb_req,
	input wire apb_rsp_t  apb_rsp,
	input wire rom_info_t rom_info,
	input wire            dl_busy,
	input wire            cheat_valid,
	input wire            cheat_clear
);

	int unsigned fail_cnt = 0;

	// No wait states on this bus
	assert property (@(posedge clk_sys) disable iff (reset) apb_rsp.pready)
		else begin
			fail_cnt++;
			$error("pready low");
		end

	assert property (@(posedge clk_sys) disable iff (reset) cheat_valid |=> !cheat_valid)
		else begin
			fail_cnt++;
			$error("cheat_valid high for two cycles");
		end

	assert property (@(posedge clk_sys) disable iff (reset) cheat_clear |=> !cheat_clear)
		else begin
			fail_cnt++;
			$error("cheat_clear high for two cycles");
		end

	// Region frozen during a download
	assert property (@(posedge clk_sys) disable iff (reset) dl_busy |=> $stable(rom_info.pal))
		else begin
			fail_cnt++;
			$error("pal changed while busy");
		end

	assert property (@(posedge clk_sys) disable iff (reset)
		apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
		else begin
			fail_cnt++;
			$error("pslverr outside an access cycle");
		end

endmodule

bind cart_loader_top cart_loader_props u_props (.clk_sys, .reset, .apb_req, .apb_rsp,
	.rom_info, .dl_busy, .cheat_valid, .cheat_clear);

`default_nettype wire

/* bench/cart_loader_tb.sv */
// Cartridge loader testbench: clock, reset, APB and download tasks, register and cheat checks
`include "cart_cfg.svh"
`default_nettype none

module cart_loader_tb
	import cart_pkg::*;
();

	logic                    clk_sys;
	logic                    reset;
	logic                    dl_active;
	logic [7:0]              dl_index;
	logic                    dl_wr;
	logic [`CART_ADDR_W-1:0] dl_addr;
	logic [`CART_DATA_W-1:0] dl_data;
	apb_req_t                apb_req;
	apb_rsp_t                apb_rsp;
	rom_info_t               rom_info;
	cheat_code_t             cheat_code;
	logic                    cheat_valid;
	logic                    cheat_clear;
	integer                  seed;
	cheat_code_t             got[$];
	int                      clear_cnt;

	cart_loader_top u_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// Codes and clear strobes as they leave the DUT
	always @(negedge clk_sys) begin
		if (cheat_valid)
			got.push_back(cheat_code);
		if (cheat_clear)
			clear_cnt++;
	end

	// Property failures end the run at once
	always @(negedge clk_sys) begin
		if (u_dut.u_props.fail_cnt != 0) begin
			$display(">>> FAIL");
			$fatal(1, "property failure");
		end
	end

	// ======================================================================
	// Drivers
	// ======================================================================
	task automatic next_cycle();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic fail_timeout(input string what);
		$display("Timeout while %s", what);
		$display(">>> FAIL");
		$fatal(1, "timeout");
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("Error %s expected %08h actual %08h", name, exp, act);
			$display(">>> FAIL");
			$fatal(1, "check failed");
		end
	endtask

	// Setup cycle, then access cycle until pready
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int n;
		next_cycle();
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = wr;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		next_cycle();
		apb_req.penable = 1'b1;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
			if (n > 16)
				fail_timeout("waiting for pready");
		end while (!apb_rsp.pready);
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		next_cycle();
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b0;
	endtask

	task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] r;
		logic        e;
		apb_xfer(1'b1, addr, data, r, e);
		check("write pslverr", 32'd0, {31'd0, e});
	endtask

	task automatic reg_expect(input string name, input logic [7:0] addr, input logic [31:0] exp);
		logic [31:0] r;
		logic        e;
		apb_xfer(1'b0, addr, 32'd0, r, e);
		check(name, exp, r);
	endtask

	task automatic dl_open(input logic [7:0] index);
		next_cycle();
		dl_index  = index;
		dl_active = 1'b1;
	endtask

	task automatic dl_put(input logic [`CART_ADDR_W-1:0] addr, input logic [15:0] data);
		next_cycle();
		dl_wr   = 1'b1;
		dl_addr = addr;
		dl_data = data;
	endtask

	// Stop writing, optionally keep the download open
	task automatic dl_stop(input logic keep_active);
		next_cycle();
		dl_wr     = 1'b0;
		dl_active = keep_active;
	endtask

	task automatic wait_idle();
		logic [31:0] r;
		logic        e;
		int          n;
		n = 0;
		do begin
			apb_xfer(1'b0, `CART_REG_INFO, 32'd0, r, e);
			n++;
			if (n > 8)
				fail_timeout("waiting for the download to end");
		end while (r[9]);
	endtask

	// 1024 << size, minus one, in 24 bits
	function automatic logic [23:0] size_mask(input logic [3:0] size, input logic zero_off);
		if (zero_off && size == 4'd0)
			return 24'd0;
		return (24'd1024 << size) - 24'd1;
	endfunction

	// ======================================================================
	// Test sequence
	// ======================================================================
	initial begin
		logic [31:0] r;
		logic        e;
		logic [7:0]  low;
		logic [3:0]  rs;
		logic [3:0]  ms;
		logic [15:0] w[24];
		int          n;
		int          k;
		int          i;
		seed      = 32'hc5e9;
		clear_cnt = 0;
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_index  = 8'h00;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		apb_req   = '0;
		repeat (5) @(posedge clk_sys);
		#10 reset = 1'b0;

		// Register access and bus errors
		reg_expect("reset ctrl", `CART_REG_CTRL, 32'd0);
		reg_expect("reset info", `CART_REG_INFO, 32'd0);
		reg_expect("reset rom mask", `CART_REG_ROM_MASK, 32'd0);
		reg_expect("reset ram mask", `CART_REG_RAM_MASK, 32'd0);
		reg_expect("reset cheats", `CART_REG_CHEATS, 32'd0);
		reg_write(`CART_REG_CTRL, 32'h0000_0123);
		reg_expect("ctrl readback", `CART_REG_CTRL, 32'h0000_0123);
		reg_expect("forced pal info", `CART_REG_INFO, 32'h0000_0100);
		check("forced pal port", 32'd1, {31'd0, rom_info.pal});
		apb_xfer(1'b0, 8'h20, 32'd0, r, e);
		check("unmapped pslverr", 32'd1, {31'd0, e});
		apb_xfer(1'b1, `CART_REG_INFO, 32'hffff_ffff, r, e);
		check("info write pslverr", 32'd1, {31'd0, e});

		// Auto header, sizes packed in word 0
		reg_write(`CART_REG_CTRL, 32'd0);
		r = $random(seed);
		low = (r[7:0] == 8'h00) ? 8'h01 : r[7:0];
		dl_open(8'h00);
		dl_put('0, {8'h21, low});
		dl_put(`CART_ADDR_W'd2, 16'h0000);
		dl_stop(1'b0);
		wait_idle();
		reg_expect("auto info", `CART_REG_INFO, 32'h0000_0021);
		reg_expect("auto rom mask", `CART_REG_ROM_MASK, {8'd0, size_mask(low[3:0], 1'b0)});
		reg_expect("auto ram mask", `CART_REG_RAM_MASK, {8'd0, size_mask(low[7:4], 1'b1)});

		// HiROM, sizes from the internal header
		reg_write(`CART_REG_CTRL, 32'h0000_0003);
		r  = $random(seed);
		rs = r[3:0];
		ms = r[7:4];
		dl_open(8'h00);
		dl_put('0, 16'h21ff);
		dl_put(`CART_HIROM_INFO + `CART_COPIER_OFS, {r[15:12], rs, r[23:16]});
		dl_put(`CART_HIROM_INFO + `CART_COPIER_OFS + `CART_ADDR_W'd2, {r[27:16], ms});
		dl_stop(1'b0);
		wait_idle();
		reg_expect("hirom info", `CART_REG_INFO, 32'h0000_0001);
		reg_expect("hirom rom mask", `CART_REG_ROM_MASK, {8'd0, size_mask(rs, 1'b0)});
		reg_expect("hirom ram mask", `CART_REG_RAM_MASK, {8'd0, size_mask(ms, 1'b1)});

		// Region from header bit 8, then forced modes
		reg_write(`CART_REG_CTRL, 32'd0);
		dl_open(8'h00);
		dl_put('0, 16'h0000);
		dl_put(`CART_ADDR_W'd2, 16'h0100);
		dl_stop(1'b0);
		wait_idle();
		reg_expect("auto region", `CART_REG_INFO, 32'h0000_0100);
		dl_open(8'h00);
		dl_put(`CART_ADDR_W'd2, 16'h0100);
		dl_stop(1'b1);
		reg_write(`CART_REG_CTRL, 32'h0000_0010);
		reg_expect("region held in download", `CART_REG_INFO, 32'h0000_0300);
		dl_stop(1'b0);
		wait_idle();
		reg_expect("forced ntsc", `CART_REG_INFO, 32'h0000_0000);
		reg_write(`CART_REG_CTRL, 32'h0000_0020);
		dl_open(8'h00);
		dl_put(`CART_ADDR_W'd2, 16'h0000);
		dl_stop(1'b0);
		wait_idle();
		reg_expect("forced pal", `CART_REG_INFO, 32'h0000_0100);

		// Three codes with cheats on
		reg_write(`CART_REG_CTRL, 32'h0000_0100);
		clear_cnt = 0;
		dl_open(`CART_CODE_INDEX);
		for (k = 0; k < 3; k++) begin
			for (i = 0; i < 8; i++) begin
				r = $random(seed);
				w[k*8+i] = r[15:0];
				dl_put(`CART_ADDR_W'(k*16 + i*2), r[15:0]);
			end
		end
		dl_stop(1'b0);
		n = 0;
		while (got.size() < 3) begin
			@(negedge clk_sys);
			n++;
			if (n > 32)
				fail_timeout("waiting for cheat codes");
		end
		for (k = 0; k < 3; k++) begin
			check("cheat flags", {w[k*8+1], w[k*8]}, got[k].flags);
			check("cheat addr", {w[k*8+3], w[k*8+2]}, got[k].addr);
			check("cheat compare", {w[k*8+5], w[k*8+4]}, got[k].compare);
			check("cheat replace", {w[k*8+7], w[k*8+6]}, got[k].replace);
		end
		check("cheat clear on list start", 32'd1, clear_cnt);
		reg_expect("cheat count", `CART_REG_CHEATS, 32'd3);
		dl_open(`CART_CODE_INDEX);
		dl_put('0, w[0]);
		dl_stop(1'b0);
		wait_idle();
		check("cheat clear on offset 0", 32'd2, clear_cnt);
		reg_expect("cheat count cleared", `CART_REG_CHEATS, 32'd0);

		// Cheats off, the strobe must stay quiet
		reg_write(`CART_REG_CTRL, 32'd0);
		dl_open(`CART_CODE_INDEX);
		for (i = 0; i < 8; i++)
			dl_put(`CART_ADDR_W'(16 + i*2), w[8+i]);
		dl_stop(1'b0);
		wait_idle();
		check("cheats disabled", 32'd3, got.size());
		check("no cheat clear mid list", 32'd2, clear_cnt);
		reg_expect("cheat count disabled", `CART_REG_CHEATS, 32'd0);

		// A new cartridge also drops the codes
		dl_open(8'h00);
		dl_put(`CART_ADDR_W'd2, 16'h0000);
		dl_stop(1'b0);
		wait_idle();
		check("cheat clear on cartridge", 32'd3, clear_cnt);

		if (u_dut.u_props.fail_cnt == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display(">>> FAIL");
			$fatal(1, "property failures");
		end
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+rtl
rtl/cart_pkg.sv
rtl/dl_classify.sv
rtl/cart_header_parser.sv
rtl/cheat_assembler.sv
rtl/cart_apb_regs.sv
rtl/cart_loader_top.sv
bench/cart_loader_props.sv
bench/cart_loader_tb.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module cart_loader_tb -f verilog.f

run: compile
	@out=$$(./obj_dir/Vcart_loader_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
